/* source/regblk_pkg.sv */
// Register block shared definitions
`default_nettype none

package regblk_pkg;

   // Register data word and register address
   typedef logic [7:0] data_t;
   typedef logic [1:0] addr_t;

   // Host request as it travels through the request FIFO
   typedef struct packed {
      logic  write;
      addr_t addr;
      data_t data;
   } reg_req_t;

   // Response carrying zero data for a write
   typedef struct packed {
      logic  write;
      data_t data;
   } reg_rsp_t;

   // Software access types of a field
   typedef enum logic [1:0] {
      SW_RW,
      SW_RO,
      SW_W1C,
      SW_RC
   } sw_access_e;

   // Hardware update types of a field
   typedef enum logic [1:0] {
      HW_NONE,
      HW_SET,
      HW_INCR
   } hw_access_e;

   // Register map
   localparam addr_t ADDR_CTRL   = 2'd0;
   localparam addr_t ADDR_CONFIG = 2'd1;
   localparam addr_t ADDR_EVENTS = 2'd2;
   localparam addr_t ADDR_COUNT  = 2'd3;

   localparam data_t RST_CTRL   = 8'h00;
   localparam data_t RST_CONFIG = 8'h5a;
   localparam data_t RST_EVENTS = 8'h00;
   localparam data_t RST_COUNT  = 8'h00;

   // CTRL bit that write-protects CONFIG
   localparam int unsigned LOCK_BIT = 7;

endpackage

`default_nettype wire

/* source/req_intake.sv */
// Request intake FIFO
`timescale 1ns/1ps
`default_nettype none

module req_intake #(
   parameter int REQ_DEPTH = 4
) (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 req_valid,
   input  wire regblk_pkg::reg_req_t req,
   output logic                      req_credit,
   output logic                      bank_valid,
   output regblk_pkg::reg_req_t      bank_req,
   input  wire logic                 bank_pop
);

   localparam int PW = $clog2(REQ_DEPTH);
   localparam int CW = $clog2(REQ_DEPTH + 1);

   regblk_pkg::reg_req_t mem [REQ_DEPTH];
   logic [PW-1:0]        wr_ptr;
   logic [PW-1:0]        rd_ptr;
   logic [CW-1:0]        count;

   // Host holds a credit for every free entry, so a write never overflows
   always_ff @(posedge clk) begin
      if (req_valid) begin
         mem[wr_ptr] <= req;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         req_credit <= 1'b0;
      end else begin
         if (req_valid) begin
            wr_ptr <= (wr_ptr == PW'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (bank_pop) begin
            rd_ptr <= (rd_ptr == PW'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count      <= count + CW'(req_valid) - CW'(bank_pop);
         // Each freed entry goes back to the host as one credit
         req_credit <= bank_pop;
      end
   end

   assign bank_valid = (count != '0);
   assign bank_req   = mem[rd_ptr];

endmodule

`default_nettype wire

/* source/sw_ctrl.sv */
// Field software access
`timescale 1ns/1ps
`default_nettype none

module sw_ctrl #(
   parameter regblk_pkg::sw_access_e SW_TYPE = regblk_pkg::SW_RW
) (
   input  wire logic              sw_wr,
   input  wire logic              sw_rd,
   input  wire regblk_pkg::data_t sw_wr_data,
   input  wire regblk_pkg::data_t value,
   output regblk_pkg::data_t      nxt_sw_value,
   output logic                   sw_modify,
   output logic                   swmod
);

   always_comb begin
      nxt_sw_value = value;
      sw_modify    = 1'b0;
      swmod        = 1'b0;
      case (SW_TYPE)
         regblk_pkg::SW_RW: begin
            nxt_sw_value = sw_wr_data;
            sw_modify    = sw_wr;
            swmod        = sw_wr;
         end
         regblk_pkg::SW_RO: begin
            // Writes have no effect
            nxt_sw_value = value;
            sw_modify    = 1'b0;
            swmod        = 1'b0;
         end
         regblk_pkg::SW_W1C: begin
            // Bits written as one are cleared, the others keep their value
            nxt_sw_value = value & ~sw_wr_data;
            sw_modify    = sw_wr;
            swmod        = sw_wr;
         end
         regblk_pkg::SW_RC: begin
            // Read returns the old value and leaves zero behind
            nxt_sw_value = '0;
            sw_modify    = sw_rd;
            swmod        = sw_rd;
         end
         default: begin
            nxt_sw_value = value;
            sw_modify    = 1'b0;
            swmod        = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* source/hw_ctrl.sv */
// Field hardware update
`timescale 1ns/1ps
`default_nettype none

module hw_ctrl #(
   parameter regblk_pkg::hw_access_e HW_TYPE = regblk_pkg::HW_NONE
) (
   input  wire logic              hw_pulse,
   input  wire regblk_pkg::data_t hw_value,
   input  wire regblk_pkg::data_t value,
   output regblk_pkg::data_t      nxt_hw_value,
   output logic                   hw_modify
);

   always_comb begin
      nxt_hw_value = value;
      hw_modify    = 1'b0;
      case (HW_TYPE)
         regblk_pkg::HW_SET: begin
            nxt_hw_value = value | hw_value;
            hw_modify    = hw_pulse;
         end
         regblk_pkg::HW_INCR: begin
            // Saturates at all ones
            nxt_hw_value = (value == '1) ? value : value + 1'b1;
            hw_modify    = hw_pulse;
         end
         default: begin
            nxt_hw_value = value;
            hw_modify    = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* source/field.sv */
// Register field
`timescale 1ns/1ps
`default_nettype none

module field #(
   parameter regblk_pkg::sw_access_e SW_TYPE   = regblk_pkg::SW_RW,
   parameter regblk_pkg::hw_access_e HW_TYPE   = regblk_pkg::HW_NONE,
   parameter bit                     SW_WINS   = 1'b1,
   parameter regblk_pkg::data_t      RST_VALUE = '0
) (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire logic              sw_wr,
   input  wire logic              sw_rd,
   input  wire regblk_pkg::data_t sw_wr_data,
   input  wire logic              write_protect,
   input  wire logic              hw_pulse,
   input  wire regblk_pkg::data_t hw_value,
   output regblk_pkg::data_t      value,
   output logic                   swmod
);

   regblk_pkg::data_t nxt_sw_value;
   regblk_pkg::data_t nxt_hw_value;
   regblk_pkg::data_t nxt_value;
   logic              sw_modify;
   logic              sw_take;
   logic              sw_pulse;
   logic              hw_modify;
   logic              upd;

   sw_ctrl #(
      .SW_TYPE (SW_TYPE)
   ) sw_ctrl_i (
      .sw_wr        (sw_wr),
      .sw_rd        (sw_rd),
      .sw_wr_data   (sw_wr_data),
      .value        (value),
      .nxt_sw_value (nxt_sw_value),
      .sw_modify    (sw_modify),
      .swmod        (sw_pulse)
   );

   hw_ctrl #(
      .HW_TYPE (HW_TYPE)
   ) hw_ctrl_i (
      .hw_pulse     (hw_pulse),
      .hw_value     (hw_value),
      .value        (value),
      .nxt_hw_value (nxt_hw_value),
      .hw_modify    (hw_modify)
   );

   // Write protect masks software changes only, hardware keeps updating
   always_comb begin
      sw_take = sw_modify & ~write_protect;
      upd     = sw_take | hw_modify;
      if (SW_WINS) begin
         nxt_value = sw_take ? nxt_sw_value : nxt_hw_value;
      end else begin
         nxt_value = hw_modify ? nxt_hw_value : nxt_sw_value;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         value <= RST_VALUE;
         swmod <= 1'b0;
      end else begin
         if (upd) begin
            value <= nxt_value;
         end
         // Only an accepted software access counts as a modification
         swmod <= sw_pulse & ~write_protect;
      end
   end

endmodule

`default_nettype wire

/* source/reg_bank.sv */
// Register bank
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 bank_valid,
   input  wire regblk_pkg::reg_req_t bank_req,
   output logic                      bank_pop,
   output logic                      rsp_push,
   output regblk_pkg::reg_rsp_t      push_rsp,
   input  wire logic                 rsp_room,
   input  wire regblk_pkg::data_t    events_set,
   input  wire logic                 events_pulse,
   input  wire logic                 count_inc,
   output regblk_pkg::data_t         ctrl_value,
   output regblk_pkg::data_t         config_value,
   output logic                      cfg_changed
);

   logic [3:0]        wr_stb;
   logic [3:0]        rd_stb;
   regblk_pkg::data_t events_value;
   regblk_pkg::data_t count_value;
   regblk_pkg::data_t rd_data;

   // A request is taken only when its response has a place to go
   assign bank_pop = bank_valid & rsp_room;
   assign rsp_push = bank_pop;

   always_comb begin
      wr_stb = '0;
      rd_stb = '0;
      if (bank_pop) begin
         if (bank_req.write) begin
            wr_stb[bank_req.addr] = 1'b1;
         end else begin
            rd_stb[bank_req.addr] = 1'b1;
         end
      end
   end

   field #(
      .SW_TYPE   (regblk_pkg::SW_RW),
      .HW_TYPE   (regblk_pkg::HW_NONE),
      .SW_WINS   (1'b1),
      .RST_VALUE (regblk_pkg::RST_CTRL)
   ) ctrl_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .sw_wr         (wr_stb[regblk_pkg::ADDR_CTRL]),
      .sw_rd         (rd_stb[regblk_pkg::ADDR_CTRL]),
      .sw_wr_data    (bank_req.data),
      .write_protect (1'b0),
      .hw_pulse      (1'b0),
      .hw_value      ('0),
      .value         (ctrl_value),
      .swmod         ()
   );

   // CONFIG is frozen while the lock bit in CTRL is set
   field #(
      .SW_TYPE   (regblk_pkg::SW_RW),
      .HW_TYPE   (regblk_pkg::HW_NONE),
      .SW_WINS   (1'b1),
      .RST_VALUE (regblk_pkg::RST_CONFIG)
   ) config_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .sw_wr         (wr_stb[regblk_pkg::ADDR_CONFIG]),
      .sw_rd         (rd_stb[regblk_pkg::ADDR_CONFIG]),
      .sw_wr_data    (bank_req.data),
      .write_protect (ctrl_value[regblk_pkg::LOCK_BIT]),
      .hw_pulse      (1'b0),
      .hw_value      ('0),
      .value         (config_value),
      .swmod         (cfg_changed)
   );

   // Hardware wins so that an event is never lost to a clear
   field #(
      .SW_TYPE   (regblk_pkg::SW_W1C),
      .HW_TYPE   (regblk_pkg::HW_SET),
      .SW_WINS   (1'b0),
      .RST_VALUE (regblk_pkg::RST_EVENTS)
   ) events_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .sw_wr         (wr_stb[regblk_pkg::ADDR_EVENTS]),
      .sw_rd         (rd_stb[regblk_pkg::ADDR_EVENTS]),
      .sw_wr_data    (bank_req.data),
      .write_protect (1'b0),
      .hw_pulse      (events_pulse),
      .hw_value      (events_set),
      .value         (events_value),
      .swmod         ()
   );

   field #(
      .SW_TYPE   (regblk_pkg::SW_RC),
      .HW_TYPE   (regblk_pkg::HW_INCR),
      .SW_WINS   (1'b1),
      .RST_VALUE (regblk_pkg::RST_COUNT)
   ) count_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .sw_wr         (wr_stb[regblk_pkg::ADDR_COUNT]),
      .sw_rd         (rd_stb[regblk_pkg::ADDR_COUNT]),
      .sw_wr_data    (bank_req.data),
      .write_protect (1'b0),
      .hw_pulse      (count_inc),
      .hw_value      ('0),
      .value         (count_value),
      .swmod         ()
   );

   // Read data is the value before any read side effect lands
   always_comb begin
      case (bank_req.addr)
         regblk_pkg::ADDR_CTRL:   rd_data = ctrl_value;
         regblk_pkg::ADDR_CONFIG: rd_data = config_value;
         regblk_pkg::ADDR_EVENTS: rd_data = events_value;
         regblk_pkg::ADDR_COUNT:  rd_data = count_value;
         default:                 rd_data = '0;
      endcase
      push_rsp.write = bank_req.write;
      push_rsp.data  = bank_req.write ? '0 : rd_data;
   end

endmodule

`default_nettype wire

/* source/rsp_emit.sv */
// Response emitter
`timescale 1ns/1ps
`default_nettype none

module rsp_emit #(
   parameter int RSP_DEPTH   = 4,
   parameter int RSP_CREDITS = 2
) (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 rsp_push,
   input  wire regblk_pkg::reg_rsp_t push_rsp,
   output logic                      rsp_room,
   output logic                      rsp_valid,
   output regblk_pkg::reg_rsp_t      rsp,
   input  wire logic                 rsp_credit
);

   localparam int PW = $clog2(RSP_DEPTH);
   localparam int CW = $clog2(RSP_DEPTH + 1);
   localparam int KW = $clog2(RSP_CREDITS + 1);

   regblk_pkg::reg_rsp_t mem [RSP_DEPTH];
   logic [PW-1:0]        wr_ptr;
   logic [PW-1:0]        rd_ptr;
   logic [CW-1:0]        count;
   logic [KW-1:0]        credits;
   logic                 send;

   assign rsp_room = (count < CW'(RSP_DEPTH));
   assign send     = (count != '0) && (credits != '0);

   always_ff @(posedge clk) begin
      if (rsp_push) begin
         mem[wr_ptr] <= push_rsp;
      end
      if (send) begin
         rsp <= mem[rd_ptr];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         credits   <= KW'(RSP_CREDITS);
         rsp_valid <= 1'b0;
      end else begin
         if (rsp_push) begin
            wr_ptr <= (wr_ptr == PW'(RSP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (send) begin
            rd_ptr <= (rd_ptr == PW'(RSP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count     <= count + CW'(rsp_push) - CW'(send);
         // One credit spent per response, one regained per consumer pulse
         credits   <= credits - KW'(send) + KW'(rsp_credit);
         rsp_valid <= send;
      end
   end

endmodule

`default_nettype wire

/* source/regblk_top.sv */
// Register block top level
`timescale 1ns/1ps
`default_nettype none

module regblk_top #(
   parameter int REQ_DEPTH   = 4,
   parameter int RSP_DEPTH   = 4,
   parameter int RSP_CREDITS = 2
) (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 req_valid,
   input  wire regblk_pkg::reg_req_t req,
   output logic                      req_credit,
   output logic                      rsp_valid,
   output regblk_pkg::reg_rsp_t      rsp,
   input  wire logic                 rsp_credit,
   input  wire regblk_pkg::data_t    events_set,
   input  wire logic                 events_pulse,
   input  wire logic                 count_inc,
   output regblk_pkg::data_t         ctrl_value,
   output regblk_pkg::data_t         config_value,
   output logic                      cfg_changed
);

   logic                 bank_valid;
   regblk_pkg::reg_req_t bank_req;
   logic                 bank_pop;
   logic                 rsp_push;
   regblk_pkg::reg_rsp_t push_rsp;
   logic                 rsp_room;

   req_intake #(
      .REQ_DEPTH (REQ_DEPTH)
   ) req_intake_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req        (req),
      .req_credit (req_credit),
      .bank_valid (bank_valid),
      .bank_req   (bank_req),
      .bank_pop   (bank_pop)
   );

   reg_bank reg_bank_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .bank_valid   (bank_valid),
      .bank_req     (bank_req),
      .bank_pop     (bank_pop),
      .rsp_push     (rsp_push),
      .push_rsp     (push_rsp),
      .rsp_room     (rsp_room),
      .events_set   (events_set),
      .events_pulse (events_pulse),
      .count_inc    (count_inc),
      .ctrl_value   (ctrl_value),
      .config_value (config_value),
      .cfg_changed  (cfg_changed)
   );

   rsp_emit #(
      .RSP_DEPTH   (RSP_DEPTH),
      .RSP_CREDITS (RSP_CREDITS)
   ) rsp_emit_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .rsp_push   (rsp_push),
      .push_rsp   (push_rsp),
      .rsp_room   (rsp_room),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .rsp_credit (rsp_credit)
   );

endmodule

`default_nettype wire

/* bench/regblk_sva.sv */
// Register block protocol assertions
`timescale 1ns/1ps
`default_nettype none

module regblk_sva #(
   parameter int REQ_DEPTH   = 4,
   parameter int RSP_CREDITS = 2
) (
   input wire logic              clk,
   input wire logic              rst_n,
   input wire logic              req_valid,
   input wire logic              req_credit,
   input wire logic              rsp_valid,
   input wire logic              rsp_credit,
   input wire regblk_pkg::data_t ctrl_value,
   input wire logic              cfg_changed
);

   int host_avail;
   int rsp_avail;
   int fail_host;
   int fail_rsp;
   int fail_reset;
   int fail_lock;
   int fail_count;

   assign fail_count = fail_host + fail_rsp + fail_reset + fail_lock;

   // Credit balances as seen at the ports
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         host_avail <= REQ_DEPTH;
         rsp_avail  <= RSP_CREDITS;
      end else begin
         host_avail <= host_avail - int'(req_valid) + int'(req_credit);
         rsp_avail  <= rsp_avail - int'(rsp_valid) + int'(rsp_credit);
      end
   end

   host_credit_a: assert property (@(posedge clk) disable iff (!rst_n)
      req_valid |-> host_avail > 0)
      else begin
         $error("Host sent a request with no request credit");
         fail_host++;
      end

   rsp_credit_a: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid |-> rsp_avail > 0)
      else begin
         $error("Response sent with no consumer credit");
         fail_rsp++;
      end

   // Skips the first edge, before the flops have seen reset
   reset_quiet_a: assert property (@(posedge clk)
      (!rst_n && $past(!rst_n)) |-> (!req_credit && !rsp_valid))
      else begin
         $error("Credit or response active during reset");
         fail_reset++;
      end

   lock_a: assert property (@(posedge clk) disable iff (!rst_n)
      cfg_changed |-> !ctrl_value[regblk_pkg::LOCK_BIT])
      else begin
         $error("CONFIG changed while locked");
         fail_lock++;
      end

endmodule

bind regblk_top regblk_sva #(
   .REQ_DEPTH   (REQ_DEPTH),
   .RSP_CREDITS (RSP_CREDITS)
) sva_i (
   .clk         (clk),
   .rst_n       (rst_n),
   .req_valid   (req_valid),
   .req_credit  (req_credit),
   .rsp_valid   (rsp_valid),
   .rsp_credit  (rsp_credit),
   .ctrl_value  (ctrl_value),
   .cfg_changed (cfg_changed)
);

`default_nettype wire

/* bench/regblk_tb.sv */
// Register block testbench
`timescale 1ns/1ps
`default_nettype none

module regblk_tb;

   localparam int REQ_DEPTH      = 4;
   localparam int RSP_DEPTH      = 4;
   localparam int RSP_CREDITS    = 2;
   localparam int CLK_PERIOD     = 100;
   localparam int N_RANDOM       = 40;
   localparam int N_EVENT_ROUNDS = 4;
   // Exactly fills both FIFOs plus the responses already granted
   localparam int N_BURST        = REQ_DEPTH + RSP_DEPTH + RSP_CREDITS;
   localparam int COUNT_SMALL    = 5;
   localparam int COUNT_LARGE    = 300;
   localparam int HOLD_CYCLES    = 20;
   localparam int DRAIN_LIMIT    = 200;
   localparam int TOTAL_REQS     = 4 + N_RANDOM + 3 * N_EVENT_ROUNDS + 4 + N_BURST;
   localparam int IDLE_CYCLES    = N_EVENT_ROUNDS + COUNT_SMALL + COUNT_LARGE + HOLD_CYCLES;
   localparam int WATCHDOG_CYCLES = TOTAL_REQS * 20 + IDLE_CYCLES + 200;

   logic                 clk;
   logic                 rst_n;
   logic                 req_valid;
   regblk_pkg::reg_req_t req;
   logic                 req_credit;
   logic                 rsp_valid;
   regblk_pkg::reg_rsp_t rsp;
   logic                 rsp_credit = 1'b0;
   regblk_pkg::data_t    events_set;
   logic                 events_pulse;
   logic                 count_inc;
   regblk_pkg::data_t    ctrl_value;
   regblk_pkg::data_t    config_value;
   logic                 cfg_changed;

   // Shadow register model and prediction queues
   regblk_pkg::data_t    shadow [4];
   regblk_pkg::reg_rsp_t exp_q [$];
   string                name_q [$];
   string                test_name;
   int                   cfg_expected;
   logic [31:0]          rng_state = 32'hb107d8c0;

   int host_credits;
   int rsp_seen;
   int credits_returned;
   int cfg_pulses;
   int cycle_count;
   int checks;
   int mismatches;
   int other_errors;
   bit hold_credits;
   bit credit_next;

   regblk_top #(
      .REQ_DEPTH   (REQ_DEPTH),
      .RSP_DEPTH   (RSP_DEPTH),
      .RSP_CREDITS (RSP_CREDITS)
   ) dut_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .req_valid    (req_valid),
      .req          (req),
      .req_credit   (req_credit),
      .rsp_valid    (rsp_valid),
      .rsp          (rsp),
      .rsp_credit   (rsp_credit),
      .events_set   (events_set),
      .events_pulse (events_pulse),
      .count_inc    (count_inc),
      .ctrl_value   (ctrl_value),
      .config_value (config_value),
      .cfg_changed  (cfg_changed)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Register map rules applied to the shadow copy in request order
   function automatic regblk_pkg::reg_rsp_t predict_rsp(input regblk_pkg::reg_req_t r);
      regblk_pkg::reg_rsp_t p;
      p.write = r.write;
      p.data  = r.write ? 8'h00 : shadow[r.addr];
      if (r.write) begin
         case (r.addr)
            regblk_pkg::ADDR_CTRL: shadow[r.addr] = r.data;
            regblk_pkg::ADDR_CONFIG: begin
               if (!shadow[regblk_pkg::ADDR_CTRL][regblk_pkg::LOCK_BIT]) begin
                  shadow[r.addr] = r.data;
                  cfg_expected++;
               end
            end
            regblk_pkg::ADDR_EVENTS: shadow[r.addr] = shadow[r.addr] & ~r.data;
            default: ;  // COUNT ignores writes
         endcase
      end else if (r.addr == regblk_pkg::ADDR_COUNT) begin
         shadow[r.addr] = 8'h00;
      end
      return p;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         mismatches++;
         $display("ERROR %s expected %0h actual %0h", name, expected, actual);
      end
   endtask

   function automatic bit bus_busy();
      return exp_q.size() != 0 || host_credits != REQ_DEPTH || rsp_seen != credits_returned;
   endfunction

   // Host credit balance, as the host sees it
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         host_credits <= REQ_DEPTH;
      end else begin
         host_credits <= host_credits - int'(req_valid) + int'(req_credit);
      end
   end

   // Response compare and consumer credit pattern
   always @(posedge clk) begin
      if (rst_n) begin
         cycle_count++;
         if (cfg_changed) begin
            cfg_pulses++;
         end
         if (rsp_valid) begin
            rsp_seen++;
            if (rsp_seen > RSP_CREDITS + credits_returned) begin
               other_errors++;
               $display("Response %0d arrived beyond the credits granted", rsp_seen);
            end
            if (exp_q.size() == 0) begin
               other_errors++;
               $display("Response arrived with no request outstanding");
            end else begin
               check_value(name_q.pop_front(), 32'(exp_q.pop_front()), 32'(rsp));
            end
         end
         // Every third cycle the consumer holds back
         if (!hold_credits && rsp_seen > credits_returned && (cycle_count % 3) != 0) begin
            credit_next = 1'b1;
            credits_returned++;
         end else begin
            credit_next = 1'b0;
         end
      end
   end

   always @(negedge clk) begin
      rsp_credit = credit_next;
   end

   // Called on a falling edge, returns on a falling edge
   task automatic send_req(input logic write, input regblk_pkg::addr_t addr,
                           input regblk_pkg::data_t data);
      regblk_pkg::reg_req_t r;
      r.write = write;
      r.addr  = addr;
      r.data  = data;
      while (host_credits == 0) begin
         req_valid = 1'b0;
         @(negedge clk);
      end
      req_valid = 1'b1;
      req       = r;
      exp_q.push_back(predict_rsp(r));
      name_q.push_back(test_name);
      @(negedge clk);
      req_valid = 1'b0;
   endtask

   task automatic wait_idle();
      int waited;
      waited = 0;
      while (bus_busy() && waited < DRAIN_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (bus_busy()) begin
         other_errors++;
         $display("Test %s did not drain within %0d cycles", test_name, DRAIN_LIMIT);
      end
   endtask

   task automatic pulse_events(input regblk_pkg::data_t bits);
      events_set   = bits;
      events_pulse = 1'b1;
      shadow[regblk_pkg::ADDR_EVENTS] = shadow[regblk_pkg::ADDR_EVENTS] | bits;
      @(negedge clk);
      events_pulse = 1'b0;
      events_set   = 8'h00;
   endtask

   task automatic pulse_count(input int n);
      int sum;
      count_inc = 1'b1;
      repeat (n) @(negedge clk);
      count_inc = 1'b0;
      sum = int'(shadow[regblk_pkg::ADDR_COUNT]) + n;
      shadow[regblk_pkg::ADDR_COUNT] = (sum > 255) ? 8'hff : 8'(sum);
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout after %0d cycles, %0d responses still expected",
               WATCHDOG_CYCLES, exp_q.size());
      $display("Regression failed");
      $finish;
   end

   initial begin
      logic [31:0] rnd;
      int          burst_start;
      rst_n        = 1'b0;
      req_valid    = 1'b0;
      req          = '0;
      events_set   = 8'h00;
      events_pulse = 1'b0;
      count_inc    = 1'b0;
      shadow[regblk_pkg::ADDR_CTRL]   = regblk_pkg::RST_CTRL;
      shadow[regblk_pkg::ADDR_CONFIG] = regblk_pkg::RST_CONFIG;
      shadow[regblk_pkg::ADDR_EVENTS] = regblk_pkg::RST_EVENTS;
      shadow[regblk_pkg::ADDR_COUNT]  = regblk_pkg::RST_COUNT;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;

      test_name = "reset values";
      for (int a = 0; a < 4; a++) begin
         send_req(1'b0, regblk_pkg::addr_t'(a), 8'h00);
      end
      wait_idle();

      // Random data sets the lock bit about half the time
      test_name = "ctrl config";
      for (int i = 0; i < N_RANDOM; i++) begin
         rnd = next_rand();
         send_req(rnd[8], rnd[9] ? regblk_pkg::ADDR_CONFIG : regblk_pkg::ADDR_CTRL, rnd[7:0]);
      end
      wait_idle();
      check_value("ctrl config cfg_changed pulses", cfg_expected, cfg_pulses);
      check_value("ctrl config ctrl_value", 32'(shadow[regblk_pkg::ADDR_CTRL]),
                  32'(ctrl_value));
      check_value("ctrl config config_value", 32'(shadow[regblk_pkg::ADDR_CONFIG]),
                  32'(config_value));

      test_name = "events";
      for (int i = 0; i < N_EVENT_ROUNDS; i++) begin
         rnd = next_rand();
         pulse_events(rnd[7:0]);
         send_req(1'b0, regblk_pkg::ADDR_EVENTS, 8'h00);
         send_req(1'b1, regblk_pkg::ADDR_EVENTS, rnd[15:8]);
         send_req(1'b0, regblk_pkg::ADDR_EVENTS, 8'h00);
         wait_idle();
      end

      test_name = "count";
      pulse_count(COUNT_SMALL);
      send_req(1'b0, regblk_pkg::ADDR_COUNT, 8'h00);
      send_req(1'b0, regblk_pkg::ADDR_COUNT, 8'h00);
      wait_idle();
      pulse_count(COUNT_LARGE);
      send_req(1'b0, regblk_pkg::ADDR_COUNT, 8'h00);
      send_req(1'b0, regblk_pkg::ADDR_COUNT, 8'h00);
      wait_idle();

      // Consumer withholds credits so the whole path backs up
      test_name   = "burst";
      burst_start = rsp_seen;
      hold_credits = 1'b1;
      for (int i = 0; i < N_BURST; i++) begin
         rnd = next_rand();
         send_req(rnd[8], regblk_pkg::addr_t'(rnd[10:9]), rnd[7:0]);
      end
      repeat (HOLD_CYCLES) @(negedge clk);
      check_value("burst responses while held", RSP_CREDITS, rsp_seen - burst_start);
      check_value("burst request credits while held", 0, host_credits);
      hold_credits = 1'b0;
      wait_idle();
      check_value("burst request credits returned", REQ_DEPTH, host_credits);
      check_value("burst ctrl_value", 32'(shadow[regblk_pkg::ADDR_CTRL]), 32'(ctrl_value));
      check_value("burst config_value", 32'(shadow[regblk_pkg::ADDR_CONFIG]),
                  32'(config_value));

      $display("Checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
               checks, mismatches, other_errors, dut_i.sva_i.fail_count);
      if (mismatches == 0 && other_errors == 0 && dut_i.sva_i.fail_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
source/regblk_pkg.sv
source/req_intake.sv
source/sw_ctrl.sv
source/hw_ctrl.sv
source/field.sv
source/reg_bank.sv
source/rsp_emit.sv
source/regblk_top.sv
bench/regblk_sva.sv
bench/regblk_tb.sv

/* Makefile */
# Verilator flow for the register block

VERILATOR ?= verilator
TOP       ?= regblk_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
